// File: vga_pkg.sv
package vga_pkg;

  // Pixel and line counters
  localparam int CNT_W = 10;

  // Word offset inside one plane, 32K words
  localparam int PLANE_OFS_W = 15;

  // Plane geometry
  localparam int WORD_W      = 16;
  localparam int NUM_PLANES  = 4;
  localparam int PLANE_SEL_W = 2;

  // One attribute bit per plane
  localparam int ATTR_W = NUM_PLANES;

  // Width of one colour channel
  localparam int CHAN_W = 4;

  // 4:4:4 colour
  typedef struct packed {
    logic [CHAN_W-1:0] r;
    logic [CHAN_W-1:0] g;
    logic [CHAN_W-1:0] b;
  } rgb_t;

  // Counters plus active-high sync and enable levels
  typedef struct packed {
    logic [CNT_W-1:0] h_count;
    logic [CNT_W-1:0] v_count;
    logic             hsync;
    logic             vsync;
    logic             video_on_h;
  } vid_timing_t;

  // Scan read request, fetch engine to plane memory
  typedef struct packed {
    logic [PLANE_SEL_W-1:0] plane;
    logic [PLANE_OFS_W-1:0] offset;
    logic                   stb;
  } scan_req_t;

  // Host write into one plane word
  typedef struct packed {
    logic                   we;
    logic [PLANE_SEL_W-1:0] plane;
    logic [PLANE_OFS_W-1:0] offset;
    logic [WORD_W-1:0]      data;
  } host_wr_t;

  // Palette entry write
  typedef struct packed {
    logic              we;
    logic [ATTR_W-1:0] index;
    rgb_t              rgb;
  } pal_wr_t;

endpackage

// File: crtc_timing.sv
module crtc_timing
  import vga_pkg::*;
#(
  parameter int H_DISPLAY    = 640,
  parameter int H_SYNC_START = 656,
  parameter int H_SYNC_END   = 752,
  parameter int H_TOTAL      = 800,
  parameter int V_DISPLAY    = 480,
  parameter int V_SYNC_START = 490,
  parameter int V_SYNC_END   = 492,
  parameter int V_TOTAL      = 525
)
(
  input  logic        clk,
  input  logic        rst,
  output vid_timing_t timing_o
);

  logic [CNT_W-1:0] h_cnt;
  logic [CNT_W-1:0] v_cnt;
  logic             h_last;
  logic             v_last;
  logic             h_active;
  logic             v_active;

  // Last pixel of a line and last line of a frame
  assign h_last = (h_cnt == CNT_W'(H_TOTAL - 1));
  assign v_last = (v_cnt == CNT_W'(V_TOTAL - 1));

  // Pixel counter steps once per clock
  always_ff @(posedge clk)
  begin
    if (rst)
      h_cnt <= '0;
    else if (h_last)
      h_cnt <= '0;
    else
      h_cnt <= h_cnt + 1'b1;
  end

  // Line counter steps at the end of each line
  always_ff @(posedge clk)
  begin
    if (rst)
      v_cnt <= '0;
    else if (h_last)
    begin
      if (v_last)
        v_cnt <= '0;
      else
        v_cnt <= v_cnt + 1'b1;
    end
  end

  // Visible ranges
  assign h_active = (h_cnt < CNT_W'(H_DISPLAY));
  assign v_active = (v_cnt < CNT_W'(V_DISPLAY));

  assign timing_o.h_count = h_cnt;
  assign timing_o.v_count = v_cnt;

  // Sync levels straight from the counter ranges
  assign timing_o.hsync = (h_cnt >= CNT_W'(H_SYNC_START)) &&
                          (h_cnt <  CNT_W'(H_SYNC_END));
  assign timing_o.vsync = (v_cnt >= CNT_W'(V_SYNC_START)) &&
                          (v_cnt <  CNT_W'(V_SYNC_END));

  // Display enable with the vertical range folded in
  assign timing_o.video_on_h = h_active && v_active;

  // Counters never reach their totals
  a_h_range: assert property (
    @(posedge clk) disable iff (rst)
    h_cnt < CNT_W'(H_TOTAL)
  );

  a_v_range: assert property (
    @(posedge clk) disable iff (rst)
    v_cnt < CNT_W'(V_TOTAL)
  );

  // Horizontal sync sits inside blanking
  a_sync_blank: assert property (
    @(posedge clk) disable iff (rst)
    !(timing_o.hsync && timing_o.video_on_h)
  );

endmodule

// File: planar_fetch.sv
module planar_fetch
  import vga_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  vid_timing_t       timing_i,
  input  logic              mode_div2_i,
  output scan_req_t         req_o,
  input  logic [WORD_W-1:0] rd_data_i,
  output logic [ATTR_W-1:0] attr_o,
  output logic              hsync_o,
  output logic              vsync_o,
  output logic              video_on_o
);

  // Fixed latency from crtc levels to the attribute
  localparam int SYNC_DELAY = 10;

  logic [CNT_W-1:0]       h;
  logic [CNT_W-1:0]       v;
  logic [CNT_W-2:0]       v_half;
  logic                   fetch_start;
  logic [7:0]             pipe;
  logic [PLANE_OFS_W-1:0] row_base_next;
  logic [5:0]             col_next;
  logic [PLANE_OFS_W-1:0] row_base;
  logic [5:0]             col;
  logic [PLANE_OFS_W-1:0] word_offset;
  logic [PLANE_SEL_W-1:0] plane_d1;
  logic [PLANE_SEL_W-1:0] plane_d2;
  logic [WORD_W-1:0]      stage_q [NUM_PLANES-1];
  logic [WORD_W-1:0]      disp_q [NUM_PLANES];
  logic [WORD_W-1:0]      bit_mask;
  logic                   hold_mask;
  logic [ATTR_W-1:0]      pix_bits;
  logic [SYNC_DELAY-1:0]  hsync_sr;
  logic [SYNC_DELAY-1:0]  vsync_sr;
  logic [SYNC_DELAY-1:0]  von_sr;

  assign h      = timing_i.h_count;
  assign v      = timing_i.v_count;
  assign v_half = v[CNT_W-1:1];

  // New word every 16 pixels, or every 32 with the halved dot clock
  assign fetch_start = mode_div2_i ? (h[4:0] == 5'd0) : (h[3:0] == 4'd0);

  // Fetch phase marker
  always_ff @(posedge clk)
  begin
    if (rst)
      pipe <= '0;
    else
      pipe <= {pipe[6:0], fetch_start};
  end

  // Row base, 40 words per line or 22 per line pair
  always_comb
  begin
    if (mode_div2_i)
      row_base_next = {2'b00, v_half, 4'b0000} + {4'b0000, v_half, 2'b00} +
                      {5'b00000, v_half, 1'b0};
    else
      row_base_next = {v, 5'b00000} + {2'b00, v, 3'b000};
    col_next = mode_div2_i ? {1'b0, h[9:5]} : h[9:4];
  end

  // Step one registers row and column, step two adds them
  always_ff @(posedge clk)
  begin
    row_base    <= row_base_next;
    col         <= col_next;
    plane_d1    <= h[1:0];
    word_offset <= row_base + {9'd0, col};
    plane_d2    <= plane_d1;
  end

  // Plane index follows the low pixel bits, one plane per phase
  assign req_o.plane  = plane_d2;
  assign req_o.offset = word_offset;
  assign req_o.stb    = |pipe[4:1];

  // Words come back three cycles after the request
  always_ff @(posedge clk)
  begin
    for (int p = 0; p < NUM_PLANES - 1; p++)
    begin
      if (pipe[4 + p])
        stage_q[p] <= rd_data_i;
    end
  end

  // Last plane arrives, move the whole set at once
  always_ff @(posedge clk)
  begin
    if (pipe[7])
    begin
      for (int p = 0; p < NUM_PLANES - 1; p++)
        disp_q[p] <= stage_q[p];
      disp_q[NUM_PLANES-1] <= rd_data_i;
    end
  end

  // Odd pixels repeat the previous bit in div2 mode
  assign hold_mask = mode_div2_i & h[0];

  // One-hot walker, bit 0 first
  always_ff @(posedge clk)
  begin
    if (rst)
      bit_mask <= '0;
    else if (!hold_mask)
      bit_mask <= {bit_mask[WORD_W-2:0], pipe[7]};
  end

  // Selected bit of each plane
  always_comb
  begin
    for (int p = 0; p < NUM_PLANES; p++)
      pix_bits[p] = |(disp_q[p] & bit_mask);
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      attr_o <= '0;
    else
      attr_o <= pix_bits;
  end

  // Syncs and enable follow the pixel pipeline
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      hsync_sr <= '0;
      vsync_sr <= '0;
      von_sr   <= '0;
    end
    else
    begin
      hsync_sr <= {hsync_sr[SYNC_DELAY-2:0], timing_i.hsync};
      vsync_sr <= {vsync_sr[SYNC_DELAY-2:0], timing_i.vsync};
      von_sr   <= {von_sr[SYNC_DELAY-2:0], timing_i.video_on_h};
    end
  end

  assign hsync_o    = hsync_sr[SYNC_DELAY-1];
  assign vsync_o    = vsync_sr[SYNC_DELAY-1];
  assign video_on_o = von_sr[SYNC_DELAY-1];

  // No scan reads while held in reset
  a_no_stb_in_reset: assert property (
    @(posedge clk)
    rst |=> !req_o.stb
  );

endmodule

// File: plane_memory.sv
module plane_memory
  import vga_pkg::*;
(
  input  logic              clk,
  input  host_wr_t          host_wr_i,
  input  scan_req_t         req_i,
  output logic [WORD_W-1:0] rd_data_o
);

  // Words per plane
  localparam int DEPTH = 2 ** PLANE_OFS_W;

  // Four planes side by side
  logic [WORD_W-1:0] mem [NUM_PLANES][DEPTH];

  // Read pipeline stages
  scan_req_t         req_q;
  logic [WORD_W-1:0] word_q;

  // Host port, one plane word per write
  always_ff @(posedge clk)
  begin
    if (host_wr_i.we)
      mem[host_wr_i.plane][host_wr_i.offset] <= host_wr_i.data;
  end

  // Stage 1, capture the request
  always_ff @(posedge clk)
  begin
    req_q <= req_i;
  end

  // Stage 2, array read
  // Only strobed phases touch the array
  always_ff @(posedge clk)
  begin
    if (req_q.stb)
      word_q <= mem[req_q.plane][req_q.offset];
  end

  // Stage 3, output register
  // Lines up with the staging phases in the fetch engine
  always_ff @(posedge clk)
  begin
    rd_data_o <= word_q;
  end

  // Host write and scan read to one word in the same cycle
  // return the old contents

endmodule

// File: attr_palette.sv
module attr_palette
  import vga_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  pal_wr_t               pal_wr_i,
  input  logic [NUM_PLANES-1:0] plane_en_i,
  input  logic [ATTR_W-1:0]     attr_i,
  input  logic                  hsync_i,
  input  logic                  vsync_i,
  input  logic                  video_on_i,
  output rgb_t                  rgb_o,
  output logic                  hsync_o,
  output logic                  vsync_o,
  output logic                  video_on_o
);

  // One entry per attribute value
  localparam int PAL_DEPTH = 2 ** ATTR_W;

  rgb_t              palette [PAL_DEPTH];
  logic [ATTR_W-1:0] index;
  rgb_t              colour;

  // Disabled planes read as zero
  assign index = attr_i & plane_en_i;

  // Black outside the display
  assign colour = video_on_i ? palette[index] : '0;

  // Register file write visible from the next cycle
  always_ff @(posedge clk)
  begin
    if (pal_wr_i.we)
      palette[pal_wr_i.index] <= pal_wr_i.rgb;
  end

  // Colour and levels move together
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rgb_o      <= '0;
      hsync_o    <= 1'b0;
      vsync_o    <= 1'b0;
      video_on_o <= 1'b0;
    end
    else
    begin
      rgb_o      <= colour;
      hsync_o    <= hsync_i;
      vsync_o    <= vsync_i;
      video_on_o <= video_on_i;
    end
  end

endmodule

// File: vga_planar_top.sv
module vga_planar_top
  import vga_pkg::*;
#(
  parameter int H_DISPLAY    = 640,
  parameter int H_SYNC_START = 656,
  parameter int H_SYNC_END   = 752,
  parameter int H_TOTAL      = 800,
  parameter int V_DISPLAY    = 480,
  parameter int V_SYNC_START = 490,
  parameter int V_SYNC_END   = 492,
  parameter int V_TOTAL      = 525
)
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  mode_div2_i,
  input  logic [NUM_PLANES-1:0] plane_en_i,
  input  host_wr_t              host_wr_i,
  input  pal_wr_t               pal_wr_i,
  output rgb_t                  rgb_o,
  output logic                  hsync_o,
  output logic                  vsync_o,
  output logic                  video_on_o
);

  // Timing to fetch
  vid_timing_t       timing;
  // Fetch to memory and back
  scan_req_t         scan_req;
  logic [WORD_W-1:0] scan_data;
  // Fetch to palette
  logic [ATTR_W-1:0] attr;
  logic              fetch_hsync;
  logic              fetch_vsync;
  logic              fetch_video_on;

  crtc_timing #(
    .H_DISPLAY    (H_DISPLAY),
    .H_SYNC_START (H_SYNC_START),
    .H_SYNC_END   (H_SYNC_END),
    .H_TOTAL      (H_TOTAL),
    .V_DISPLAY    (V_DISPLAY),
    .V_SYNC_START (V_SYNC_START),
    .V_SYNC_END   (V_SYNC_END),
    .V_TOTAL      (V_TOTAL)
  ) u_crtc (
    .clk      (clk),
    .rst      (rst),
    .timing_o (timing)
  );

  planar_fetch u_fetch (
    .clk         (clk),
    .rst         (rst),
    .timing_i    (timing),
    .mode_div2_i (mode_div2_i),
    .req_o       (scan_req),
    .rd_data_i   (scan_data),
    .attr_o      (attr),
    .hsync_o     (fetch_hsync),
    .vsync_o     (fetch_vsync),
    .video_on_o  (fetch_video_on)
  );

  plane_memory u_mem (
    .clk       (clk),
    .host_wr_i (host_wr_i),
    .req_i     (scan_req),
    .rd_data_o (scan_data)
  );

  attr_palette u_pal (
    .clk        (clk),
    .rst        (rst),
    .pal_wr_i   (pal_wr_i),
    .plane_en_i (plane_en_i),
    .attr_i     (attr),
    .hsync_i    (fetch_hsync),
    .vsync_i    (fetch_vsync),
    .video_on_i (fetch_video_on),
    .rgb_o      (rgb_o),
    .hsync_o    (hsync_o),
    .vsync_o    (vsync_o),
    .video_on_o (video_on_o)
  );

endmodule

// File: tb_vga_planar.sv
module tb_vga_planar
  import vga_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  // Short frames with full-width lines
  localparam int H_DISPLAY    = 640;
  localparam int H_SYNC_START = 656;
  localparam int H_SYNC_END   = 752;
  localparam int H_TOTAL      = 800;
  localparam int V_DISPLAY    = 24;
  localparam int V_SYNC_START = 30;
  localparam int V_SYNC_END   = 32;
  localparam int V_TOTAL      = 40;

  localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
  // Enough words per plane for 24 lines of 40 words
  localparam int MEM_WORDS    = 1024;
  localparam int PAL_ENTRIES  = 16;
  // Ten delay stages in the fetch engine plus the palette register
  localparam int OUT_DELAY    = 11;

  logic                  clk;
  logic                  rst;
  logic                  mode_div2_i;
  logic [NUM_PLANES-1:0] plane_en_i;
  host_wr_t              host_wr_i;
  pal_wr_t               pal_wr_i;
  rgb_t                  rgb_o;
  logic                  hsync_o;
  logic                  vsync_o;
  logic                  video_on_o;

  integer seed;
  int     checks;
  int     errors;
  bit     timed_out;

  // Reference copies of the memory and the palette
  logic [WORD_W-1:0] plane_model [NUM_PLANES][MEM_WORDS];
  logic [11:0]       pal_model [PAL_ENTRIES];

  vga_planar_top #(
    .H_DISPLAY    (H_DISPLAY),
    .H_SYNC_START (H_SYNC_START),
    .H_SYNC_END   (H_SYNC_END),
    .H_TOTAL      (H_TOTAL),
    .V_DISPLAY    (V_DISPLAY),
    .V_SYNC_START (V_SYNC_START),
    .V_SYNC_END   (V_SYNC_END),
    .V_TOTAL      (V_TOTAL)
  ) UUT (
    .clk         (clk),
    .rst         (rst),
    .mode_div2_i (mode_div2_i),
    .plane_en_i  (plane_en_i),
    .host_wr_i   (host_wr_i),
    .pal_wr_i    (pal_wr_i),
    .rgb_o       (rgb_o),
    .hsync_o     (hsync_o),
    .vsync_o     (vsync_o),
    .video_on_o  (video_on_o)
  );

  // 40 ns period
  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
    checks++;
    assert (exp_val === act_val)
    else
    begin
      $display("Mismatch in %s: expected %0h, actual %0h", name, exp_val, act_val);
      errors++;
    end
  endtask

  // Reports a missing event and holds the caller until the run ends
  task automatic abort_on_timeout(input string what);
    $display("Error: %s did not arrive within the timeout", what);
    timed_out = 1'b1;
    forever @(negedge clk);
  endtask

  initial
  begin
    wait (timed_out);
    $display("Test failed");
    $finish;
  end

  task automatic wait_vsync_rise();
    logic prev;
    int   n;
    bit   done;
    prev = vsync_o;
    n    = 0;
    done = 1'b0;
    while (!done)
    begin
      @(negedge clk);
      if (!prev && vsync_o)
        done = 1'b1;
      else if (n == 2 * FRAME_CYCLES)
        abort_on_timeout("vsync_o rising edge");
      prev = vsync_o;
      n++;
    end
  endtask

  // Returns on the first negedge sample with the display on
  task automatic wait_video_on();
    int n;
    n = 0;
    while (!video_on_o)
    begin
      if (n == FRAME_CYCLES)
        abort_on_timeout("video_on_o");
      @(negedge clk);
      n++;
    end
  endtask

  task automatic load_planes();
    logic [31:0] word;
    int          p;
    int          a;
    for (p = 0; p < NUM_PLANES; p++)
    begin
      for (a = 0; a < MEM_WORDS; a++)
      begin
        @(negedge clk);
        word                = $random(seed);
        host_wr_i.we        = 1'b1;
        host_wr_i.plane     = PLANE_SEL_W'(p);
        host_wr_i.offset    = PLANE_OFS_W'(a);
        host_wr_i.data      = word[15:0];
        plane_model[p][a]   = word[15:0];
      end
    end
    @(negedge clk);
    host_wr_i.we = 1'b0;
  endtask

  task automatic write_palette();
    logic [31:0] word;
    int          idx;
    for (idx = 0; idx < PAL_ENTRIES; idx++)
    begin
      @(negedge clk);
      word           = $random(seed);
      pal_wr_i.we    = 1'b1;
      pal_wr_i.index = ATTR_W'(idx);
      pal_wr_i.rgb   = word[11:0];
      pal_model[idx] = word[11:0];
    end
    @(negedge clk);
    pal_wr_i.we = 1'b0;
  endtask

  // Colour of pixel h on display line v
  function automatic logic [11:0] expected_rgb(input int v, input int h, input bit div2,
                                               input logic [3:0] en);
    int         word;
    int         bitn;
    int         p;
    logic [3:0] attr;
    if (div2)
    begin
      // 22 words per line pair with each bit held two pixels
      word = (v / 2) * 22 + h / 32;
      bitn = (h % 32) / 2;
    end
    else
    begin
      word = v * 40 + h / 16;
      bitn = h % 16;
    end
    for (p = 0; p < NUM_PLANES; p++)
      attr[p] = plane_model[p][word][bitn];
    return pal_model[attr & en];
  endfunction

  // Setup happens in vertical blanking just after vsync_o
  task automatic check_frame(input string name, input bit div2, input logic [3:0] en,
                             input bit new_pal);
    int          line;
    int          i;
    int          von_cnt;
    int          hs_cnt;
    logic [11:0] prev_rgb;
    wait_vsync_rise();
    mode_div2_i = div2;
    plane_en_i  = en;
    if (new_pal)
      write_palette();
    for (line = 0; line < V_DISPLAY; line++)
    begin
      wait_video_on();
      von_cnt  = 0;
      hs_cnt   = 0;
      prev_rgb = '0;
      // One whole line from the first displayed pixel
      for (i = 0; i < H_TOTAL; i++)
      begin
        if (i < H_DISPLAY)
          check_value(name, 32'(expected_rgb(line, i, div2, en)), 32'(rgb_o));
        else
          check_value({name, " blanking"}, 32'd0, 32'(rgb_o));
        // Pixel pairs in div2 mode
        if (div2 && i[0] && (i < H_DISPLAY))
          check_value({name, " pair"}, 32'(prev_rgb), 32'(rgb_o));
        prev_rgb = rgb_o;
        if (video_on_o)
          von_cnt++;
        if (hsync_o)
          hs_cnt++;
        @(negedge clk);
      end
      check_value({name, " video_on width"}, H_DISPLAY, von_cnt);
      check_value({name, " hsync width"}, H_SYNC_END - H_SYNC_START, hs_cnt);
    end
  endtask

  // No display after the last line up to the next vsync_o
  task automatic count_extra_display(input string name);
    logic prev;
    int   n;
    int   extra;
    bit   done;
    prev  = vsync_o;
    n     = 0;
    extra = 0;
    done  = 1'b0;
    while (!done)
    begin
      if (video_on_o)
        extra++;
      @(negedge clk);
      n++;
      if (!prev && vsync_o)
        done = 1'b1;
      else if (n > FRAME_CYCLES)
        abort_on_timeout("vsync_o after the display lines");
      prev = vsync_o;
    end
    check_value({name, " extra display"}, 32'd0, extra);
    // vsync_o starts a fixed number of whole lines after the display ends
    check_value({name, " vsync position"}, (V_SYNC_START - V_DISPLAY) * H_TOTAL, n);
  endtask

  // Outputs stay quiet until the first displayed pixel
  task automatic check_reset();
    int n;
    n = 0;
    while (!video_on_o)
    begin
      check_value("reset", 32'd0, 32'({hsync_o, vsync_o, rgb_o}));
      if (n == FRAME_CYCLES)
        abort_on_timeout("first displayed line");
      @(negedge clk);
      n++;
    end
    // Counters start on a displayed pixel when reset drops
    check_value("reset latency", OUT_DELAY, n);
  endtask

  task automatic report_test(input string name, input int err_before);
    $display("%s finished, %0d errors", name, errors - err_before);
  endtask

  initial
  begin
    int          err0;
    int          k;
    logic [31:0] word;
    seed        = 7;
    checks      = 0;
    errors      = 0;
    timed_out   = 1'b0;
    rst         = 1'b1;
    mode_div2_i = 1'b0;
    plane_en_i  = 4'hf;
    host_wr_i   = '0;
    pal_wr_i    = '0;

    // Three rising edges in reset
    repeat (3) @(negedge clk);
    rst = 1'b0;

    err0 = errors;
    check_reset();
    report_test("reset", err0);

    // Random contents for every test below
    load_planes();
    write_palette();

    err0 = errors;
    check_frame("normal", 1'b0, 4'hf, 1'b0);
    report_test("normal", err0);

    err0 = errors;
    check_frame("div2", 1'b1, 4'hf, 1'b0);
    report_test("div2", err0);

    // Random masks in both modes
    err0 = errors;
    for (k = 0; k < 3; k++)
    begin
      word = $random(seed);
      check_frame("plane_en", k[0], word[3:0], 1'b0);
    end
    report_test("plane_en", err0);

    err0 = errors;
    check_frame("palette", 1'b0, 4'hf, 1'b1);
    report_test("palette", err0);

    err0 = errors;
    check_frame("sync", 1'b0, 4'hf, 1'b0);
    count_extra_display("sync");
    report_test("sync", err0);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

// File: files.f
vga_pkg.sv
crtc_timing.sv
planar_fetch.sv
plane_memory.sv
attr_palette.sv
vga_planar_top.sv
tb_vga_planar.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_vga_planar -f files.f -o sim_tb

./obj_dir/sim_tb | tee sim.log

# Exit status follows the result line in the log
grep -q "^Test passed$" sim.log
